/* Makefile */
# Verilator build and run of the chipset testbench

VERILATOR ?= verilator
TOP       ?= chipset_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) verif/chipset_tests.svh
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
+incdir+verif
verilog/chipset_pkg.sv
verilog/cpu_bus_if.sv
verilog/byte_ram.sv
verilog/memory_space.sv
verilog/io_space.sv
verilog/read_data_mux.sv
verilog/chipset_top.sv
verif/chipset_tb.sv

/* verif/chipset_tests.svh */
/*
 * chipset directed tests
 * reset state, ram and video windows, i/o decode, ppi and keyboard
 */

task automatic test_reset_state();
    int errors_before;
    errors_before = error_count;
    bus_idle();
    @(negedge clock);
    check_read("reset_state read", make_result(1'b0, 8'h00), observed_result());
    check_data("reset_state port b", 8'h00, port_b);
    check_bit("reset_state irq", 1'b0, keyboard_interrupt);
    end_test("reset_state", errors_before);
endtask

task automatic test_main_ram();
    int                 errors_before;
    int                 i;
    logic [14:0]        offset;
    logic [14:0]        offsets[$];
    chipset_pkg::data_t value;
    errors_before = error_count;
    for (i = 0; i < RAM_WRITES; i++) begin
        offset = 15'(rand_bits(15));
        value  = chipset_pkg::data_t'(rand_bits(8));
        mem_write({5'b0, offset}, value);
        main_model[offset] = value;
        offsets.push_back(offset);
    end
    for (i = 0; i < offsets.size(); i++) begin
        queue_read({5'b0, offsets[i]}, KIND_MEM, make_result(1'b1, main_model[offsets[i]]));
    end
    run_reads("main_ram");
    end_test("main_ram", errors_before);
endtask

task automatic test_video_windows();
    int                 errors_before;
    int                 i;
    logic [14:0]        offset;
    logic [14:0]        offsets[$];
    chipset_pkg::data_t value;
    errors_before = error_count;
    @(posedge clock);
    enable_cga <= 1'b1;
    enable_mda <= 1'b1;
    for (i = 0; i < VIDEO_WRITES; i++) begin
        offset = 15'(rand_bits(15));
        value  = chipset_pkg::data_t'(rand_bits(8));
        mem_write(20'hB0000 + {5'b0, offset}, value);
        mda_model[offset] = value;
        offsets.push_back(offset);
    end
    // same offsets in the cga window, mda bytes must survive
    for (i = 0; i < offsets.size(); i++) begin
        value = chipset_pkg::data_t'(rand_bits(8));
        mem_write(20'hB8000 + {5'b0, offsets[i]}, value);
        cga_model[offsets[i]] = value;
    end
    for (i = 0; i < offsets.size(); i++) begin
        queue_read(20'hB0000 + {5'b0, offsets[i]}, KIND_MEM,
                   make_result(1'b1, mda_model[offsets[i]]));
        queue_read(20'hB8000 + {5'b0, offsets[i]}, KIND_MEM,
                   make_result(1'b1, cga_model[offsets[i]]));
    end
    run_reads("video_windows both enabled");
    @(posedge clock);
    enable_cga <= 1'b0;
    for (i = 0; i < offsets.size(); i++) begin
        queue_read(20'hB8000 + {5'b0, offsets[i]}, KIND_MEM, make_result(1'b0, 8'h00));
        queue_read(20'hB0000 + {5'b0, offsets[i]}, KIND_MEM,
                   make_result(1'b1, mda_model[offsets[i]]));
    end
    run_reads("video_windows cga disabled");
    @(posedge clock);
    enable_mda <= 1'b0;
    for (i = 0; i < offsets.size(); i++) begin
        queue_read(20'hB0000 + {5'b0, offsets[i]}, KIND_MEM, make_result(1'b0, 8'h00));
    end
    run_reads("video_windows mda disabled");
    end_test("video_windows", errors_before);
endtask

task automatic decode_step(
    input string name,
    input chipset_pkg::addr_t addr,
    input logic enable_n,
    input logic exp_dma_n,
    input logic exp_page_n
);
    @(posedge clock);
    address          <= addr;
    address_enable_n <= enable_n;
    @(negedge clock);
    check_bit({name, " dma select"}, exp_dma_n, dma_chip_select_n);
    check_bit({name, " dma page select"}, exp_page_n, dma_page_chip_select_n);
endtask

task automatic test_io_decode();
    int errors_before;
    errors_before = error_count;
    bus_idle();
    decode_step("io_decode 0x000", 20'h00000, 1'b0, 1'b0, 1'b1);
    decode_step("io_decode 0x080", 20'h00080, 1'b0, 1'b1, 1'b0);
    decode_step("io_decode 0x000 aen high", 20'h00000, 1'b1, 1'b1, 1'b1);
    decode_step("io_decode 0x080 aen high", 20'h00080, 1'b1, 1'b1, 1'b1);
    decode_step("io_decode 0x100", 20'h00100, 1'b0, 1'b1, 1'b1);
    decode_step("io_decode 0x180", 20'h00180, 1'b0, 1'b1, 1'b1);
    @(posedge clock);
    address_enable_n <= 1'b0;
    end_test("io_decode", errors_before);
endtask

task automatic test_port_b();
    int                 errors_before;
    chipset_pkg::data_t port_value;
    errors_before = error_count;
    port_value = chipset_pkg::data_t'(rand_bits(8));
    // ram byte under the same address holds a different value
    mem_write(20'h00061, ~port_value);
    io_write(20'h00061, port_value);
    bus_idle();
    @(negedge clock);
    check_data("port_b latch", port_value, port_b);
    queue_read(20'h00061, KIND_IO, make_result(1'b1, port_value));
    queue_read(20'h00061, KIND_BOTH, make_result(1'b1, port_value));
    queue_read(20'h00061, KIND_MEM, make_result(1'b1, ~port_value));
    queue_read(20'h00063, KIND_IO, make_result(1'b0, 8'h00));
    run_reads("port_b read");
    end_test("port_b", errors_before);
endtask

task automatic irq_step(input logic value);
    @(posedge clock);
    keyboard_irq <= value;
    @(negedge clock);
    check_bit("keyboard irq before first edge", ~value, keyboard_interrupt);
    @(negedge clock);
    check_bit("keyboard irq after one edge", ~value, keyboard_interrupt);
    @(negedge clock);
    check_bit("keyboard irq after two edges", value, keyboard_interrupt);
endtask

task automatic test_keyboard();
    int                 errors_before;
    chipset_pkg::data_t old_code;
    chipset_pkg::data_t new_code;
    errors_before = error_count;
    old_code = keycode;
    new_code = chipset_pkg::data_t'(rand_bits(8));
    if (new_code == old_code) begin
        new_code = ~new_code;
    end
    @(posedge clock);
    keycode <= new_code;
    // first read still sees the old code, the second sees the new one
    queue_read(20'h00060, KIND_IO, make_result(1'b1, old_code));
    queue_read(20'h00060, KIND_IO, make_result(1'b1, new_code));
    run_reads("keyboard port a");
    irq_step(1'b1);
    irq_step(1'b0);
    end_test("keyboard", errors_before);
endtask

/* verif/chipset_tb.sv */
/*
 * chipset testbench
 * clock, reset, random source, compare tasks and the final report
 * around the chipset top level
 */
`timescale 1ns/1ps

module chipset_tb;

    localparam int RAM_WRITES   = 512;
    localparam int VIDEO_WRITES = 128;
    // the full test list runs close to 2000 cycles
    localparam int MAX_CYCLES   = 4000;

    localparam int KIND_MEM  = 0;
    localparam int KIND_IO   = 1;
    localparam int KIND_BOTH = 2;

    logic               clock = 1'b0;
    logic               reset;
    chipset_pkg::addr_t address;
    chipset_pkg::data_t data_bus;
    logic               io_read_n;
    logic               io_write_n;
    logic               memory_read_n;
    logic               memory_write_n;
    logic               address_enable_n;
    logic               enable_cga;
    logic               enable_mda;
    chipset_pkg::data_t keycode;
    logic               keyboard_irq;
    chipset_pkg::data_t data_bus_out;
    logic               data_bus_out_from_chipset;
    logic               dma_chip_select_n;
    logic               dma_page_chip_select_n;
    logic               keyboard_interrupt;
    chipset_pkg::data_t port_b;

    logic [31:0] lfsr = 32'h917e_ac37;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    // pending reads for the pipelined read task
    chipset_pkg::addr_t        req_addr[$];
    int                        req_kind[$];
    chipset_pkg::read_result_t req_exp[$];

    // ram models, keyed by offset inside the window
    chipset_pkg::data_t main_model [logic [14:0]];
    chipset_pkg::data_t cga_model [logic [14:0]];
    chipset_pkg::data_t mda_model [logic [14:0]];

    always #2 clock = ~clock;

    chipset_top DUT (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_bus_i                  (data_bus),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .memory_write_n_i            (memory_write_n),
        .address_enable_n_i          (address_enable_n),
        .enable_cga_i                (enable_cga),
        .enable_mda_i                (enable_mda),
        .keycode_i                   (keycode),
        .keyboard_irq_i              (keyboard_irq),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset),
        .dma_chip_select_n_o         (dma_chip_select_n),
        .dma_page_chip_select_n_o    (dma_page_chip_select_n),
        .keyboard_interrupt_o        (keyboard_interrupt),
        .port_b_o                    (port_b)
    );

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr     = {lfsr[30:0], feedback};
            value    = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic chipset_pkg::read_result_t make_result(
        input logic hit,
        input chipset_pkg::data_t data
    );
        chipset_pkg::read_result_t result;
        result.hit  = hit;
        result.data = data;
        return result;
    endfunction

    function automatic chipset_pkg::read_result_t observed_result();
        return make_result(data_bus_out_from_chipset, data_bus_out);
    endfunction

    task automatic check_read(
        input string name,
        input chipset_pkg::read_result_t expected,
        input chipset_pkg::read_result_t actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected hit %b data %h, actual hit %b data %h",
                     name, expected.hit, expected.data, actual.hit, actual.data);
        end
    endtask

    task automatic check_data(
        input string name,
        input chipset_pkg::data_t expected,
        input chipset_pkg::data_t actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic bus_idle();
        @(posedge clock);
        io_read_n      <= 1'b1;
        io_write_n     <= 1'b1;
        memory_read_n  <= 1'b1;
        memory_write_n <= 1'b1;
    endtask

    task automatic mem_write(input chipset_pkg::addr_t addr, input chipset_pkg::data_t value);
        @(posedge clock);
        address        <= addr;
        data_bus       <= value;
        memory_write_n <= 1'b0;
        memory_read_n  <= 1'b1;
        io_read_n      <= 1'b1;
        io_write_n     <= 1'b1;
    endtask

    task automatic io_write(input chipset_pkg::addr_t addr, input chipset_pkg::data_t value);
        @(posedge clock);
        address        <= addr;
        data_bus       <= value;
        io_write_n     <= 1'b0;
        io_read_n      <= 1'b1;
        memory_read_n  <= 1'b1;
        memory_write_n <= 1'b1;
    endtask

    task automatic queue_read(
        input chipset_pkg::addr_t addr,
        input int kind,
        input chipset_pkg::read_result_t expected
    );
        req_addr.push_back(addr);
        req_kind.push_back(kind);
        req_exp.push_back(expected);
    endtask

    // one read per cycle, each result checked one cycle after its strobe
    task automatic run_reads(input string name);
        int n;
        int i;
        n = req_addr.size();
        for (i = 0; i <= n; i++) begin
            @(posedge clock);
            memory_write_n <= 1'b1;
            io_write_n     <= 1'b1;
            if (i < n) begin
                address       <= req_addr[i];
                memory_read_n <= (req_kind[i] == KIND_IO);
                io_read_n     <= (req_kind[i] == KIND_MEM);
            end else begin
                memory_read_n <= 1'b1;
                io_read_n     <= 1'b1;
            end
            @(negedge clock);
            if (i > 0) begin
                check_read(name, req_exp[i-1], observed_result());
            end
        end
        req_addr.delete();
        req_kind.delete();
        req_exp.delete();
    endtask

    `include "chipset_tests.svh"

    initial begin
        reset            = 1'b1;
        address          = '0;
        data_bus         = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        memory_read_n    = 1'b1;
        memory_write_n   = 1'b1;
        address_enable_n = 1'b0;
        enable_cga       = 1'b0;
        enable_mda       = 1'b0;
        keycode          = '0;
        keyboard_irq     = 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        test_reset_state();
        test_main_ram();
        test_video_windows();
        test_io_decode();
        test_port_b();
        test_keyboard();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/byte_ram.sv */
/*
 * byte ram
 * single-port synchronous byte array, depth set by the address width
 */
`timescale 1ns/1ps

module byte_ram #(
    parameter int AW = 15
) (
    input  logic                 clock,
    input  logic                 enable_i,
    input  logic                 write_i,
    input  logic [AW-1:0]        addr_i,
    input  chipset_pkg::data_t   wdata_i,
    output chipset_pkg::data_t   rdata_o
);

    chipset_pkg::data_t mem [2**AW];

    // read-first port, one cycle read latency
    always_ff @(posedge clock) begin
        if (enable_i) begin
            if (write_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* verilog/chipset_pkg.sv */
/*
 * chipset package
 * address map, bus widths and the read result type shared by the
 * peripheral glue of the XT-class chipset
 */
package chipset_pkg;

    // cpu bus
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // local storage sizes, 32 KB each
    localparam int RAM_AW  = 15;
    localparam int VRAM_AW = 15;

    // memory region tags, taken from the top address bits
    // B8000 - BFFFF
    localparam logic [5:0] CGA_BASE_TAG = 6'b1011_10;
    // B0000 - B7FFF
    localparam logic [5:0] MDA_BASE_TAG = 6'b1011_00;
    // 00000 - 07FFF
    localparam logic [4:0] RAM_BASE_TAG = 5'b00000;

    // 32-byte i/o slots below port 0x100
    localparam logic [2:0] SLOT_DMA      = 3'd0;
    localparam logic [2:0] SLOT_PIC      = 3'd1;
    localparam logic [2:0] SLOT_PIT      = 3'd2;
    localparam logic [2:0] SLOT_PPI      = 3'd3;
    localparam logic [2:0] SLOT_DMA_PAGE = 3'd4;

    // ppi register offsets
    localparam logic [1:0] PORT_A_OFFSET = 2'd0;
    localparam logic [1:0] PORT_B_OFFSET = 2'd1;

    // registered read data from one side of the chipset
    typedef struct packed {
        logic  hit;
        data_t data;
    } read_result_t;

endpackage

/* verilog/chipset_top.sv */
/*
 * chipset top
 * peripheral glue and local storage of the xt-class board
 */
`timescale 1ns/1ps

module chipset_top #(
    parameter int RAM_AW  = chipset_pkg::RAM_AW,
    parameter int VRAM_AW = chipset_pkg::VRAM_AW
) (
    input  logic               clock,
    input  logic               reset,
    // cpu bus
    input  chipset_pkg::addr_t address_i,
    input  chipset_pkg::data_t data_bus_i,
    input  logic               io_read_n_i,
    input  logic               io_write_n_i,
    input  logic               memory_read_n_i,
    input  logic               memory_write_n_i,
    input  logic               address_enable_n_i,
    // video window enables
    input  logic               enable_cga_i,
    input  logic               enable_mda_i,
    // keyboard
    input  chipset_pkg::data_t keycode_i,
    input  logic               keyboard_irq_i,
    // read-back
    output chipset_pkg::data_t data_bus_out_o,
    output logic               data_bus_out_from_chipset_o,
    // selects and peripherals
    output logic               dma_chip_select_n_o,
    output logic               dma_page_chip_select_n_o,
    output logic               keyboard_interrupt_o,
    output chipset_pkg::data_t port_b_o
);

    chipset_pkg::read_result_t memory_result;
    chipset_pkg::read_result_t io_result;

    cpu_bus_if bus ();

    assign bus.address          = address_i;
    assign bus.wdata            = data_bus_i;
    assign bus.io_read_n        = io_read_n_i;
    assign bus.io_write_n       = io_write_n_i;
    assign bus.memory_read_n    = memory_read_n_i;
    assign bus.memory_write_n   = memory_write_n_i;
    assign bus.address_enable_n = address_enable_n_i;

    memory_space #(
        .RAM_AW  (RAM_AW),
        .VRAM_AW (VRAM_AW)
    ) u_memory_space (
        .clock        (clock),
        .reset        (reset),
        .bus          (bus),
        .enable_cga_i (enable_cga_i),
        .enable_mda_i (enable_mda_i),
        .result_o     (memory_result)
    );

    io_space u_io_space (
        .clock                    (clock),
        .reset                    (reset),
        .bus                      (bus),
        .keycode_i                (keycode_i),
        .keyboard_irq_i           (keyboard_irq_i),
        .dma_chip_select_n_o      (dma_chip_select_n_o),
        .dma_page_chip_select_n_o (dma_page_chip_select_n_o),
        .keyboard_interrupt_o     (keyboard_interrupt_o),
        .port_b_o                 (port_b_o),
        .result_o                 (io_result)
    );

    read_data_mux u_read_data_mux (
        .io_result_i                 (io_result),
        .memory_result_i             (memory_result),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* verilog/cpu_bus_if.sv */
/*
 * cpu bus bundle
 * address, write data and the active-low strobes of the 8-bit cpu bus
 */
`timescale 1ns/1ps

interface cpu_bus_if;

    chipset_pkg::addr_t address;
    chipset_pkg::data_t wdata;

    // strobes are active low, as on the isa bus
    logic io_read_n;
    logic io_write_n;
    logic memory_read_n;
    logic memory_write_n;

    // high during dma cycles, blocks every select
    logic address_enable_n;

    modport target (
        input address,
        input wdata,
        input io_read_n,
        input io_write_n,
        input memory_read_n,
        input memory_write_n,
        input address_enable_n
    );

endinterface

/* verilog/io_space.sv */
/*
 * i/o space
 * slot decode below port 0x100, keyboard synchronizers and the
 * cut-down ppi with its registered read-back
 */
`timescale 1ns/1ps

module io_space (
    input  logic                       clock,
    input  logic                       reset,
    cpu_bus_if.target                  bus,
    input  chipset_pkg::data_t         keycode_i,
    input  logic                       keyboard_irq_i,
    output logic                       dma_chip_select_n_o,
    output logic                       dma_page_chip_select_n_o,
    output logic                       keyboard_interrupt_o,
    output chipset_pkg::data_t         port_b_o,
    output chipset_pkg::read_result_t  result_o
);

    logic [7:0]         chip_select_n;
    logic               ppi_chip_select_n;
    logic               port_a_read;
    logic               port_b_read;
    logic               keyboard_irq_ff;
    chipset_pkg::data_t keycode_ff;
    chipset_pkg::data_t port_a;
    logic               read_hit_q;
    chipset_pkg::data_t read_data_q;

    // one select per 32-byte slot, only for ports below 0x100
    always_comb begin
        if (~bus.address_enable_n && bus.address[9:8] == 2'b00) begin
            chip_select_n = ~(8'b0000_0001 << bus.address[7:5]);
        end else begin
            chip_select_n = 8'b1111_1111;
        end
    end

    assign dma_chip_select_n_o      = chip_select_n[chipset_pkg::SLOT_DMA];
    assign dma_page_chip_select_n_o = chip_select_n[chipset_pkg::SLOT_DMA_PAGE];
    assign ppi_chip_select_n        = chip_select_n[chipset_pkg::SLOT_PPI];

    // two-flop synchronizers for the keyboard side
    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_ff           <= '0;
            port_a               <= '0;
            keyboard_irq_ff      <= 1'b0;
            keyboard_interrupt_o <= 1'b0;
        end else begin
            keycode_ff           <= keycode_i;
            port_a               <= keycode_ff;
            keyboard_irq_ff      <= keyboard_irq_i;
            keyboard_interrupt_o <= keyboard_irq_ff;
        end
    end

    // port b latch
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_o <= '0;
        end else if (~ppi_chip_select_n && ~bus.io_write_n
                     && bus.address[1:0] == chipset_pkg::PORT_B_OFFSET) begin
            port_b_o <= bus.wdata;
        end
    end

    assign port_a_read = ~ppi_chip_select_n & ~bus.io_read_n
                       & (bus.address[1:0] == chipset_pkg::PORT_A_OFFSET);
    assign port_b_read = ~ppi_chip_select_n & ~bus.io_read_n
                       & (bus.address[1:0] == chipset_pkg::PORT_B_OFFSET);

    always_ff @(posedge clock) begin
        if (reset) begin
            read_hit_q <= 1'b0;
        end else begin
            read_hit_q <= port_a_read | port_b_read;
        end
    end

    always_ff @(posedge clock) begin
        read_data_q <= port_a_read ? port_a : port_b_o;
    end

    assign result_o.hit  = read_hit_q;
    assign result_o.data = read_data_q;

endmodule

/* verilog/memory_space.sv */
/*
 * memory space
 * decodes main ram and the cga/mda text windows, holds the three
 * byte rams and returns registered read data with a hit flag
 */
`timescale 1ns/1ps

module memory_space #(
    parameter int RAM_AW  = chipset_pkg::RAM_AW,
    parameter int VRAM_AW = chipset_pkg::VRAM_AW
) (
    input  logic                       clock,
    input  logic                       reset,
    cpu_bus_if.target                  bus,
    input  logic                       enable_cga_i,
    input  logic                       enable_mda_i,
    output chipset_pkg::read_result_t  result_o
);

    // the video windows span VRAM_AW bits, so the tag is cut to fit
    localparam int VRAM_TAG_W = chipset_pkg::ADDR_W - VRAM_AW;

    logic               ram_sel;
    logic               cga_sel;
    logic               mda_sel;
    logic               access;
    logic [2:0]         read_sel_q;
    chipset_pkg::data_t ram_rdata;
    chipset_pkg::data_t cga_rdata;
    chipset_pkg::data_t mda_rdata;

    assign ram_sel = ~bus.address_enable_n
                   & (bus.address[chipset_pkg::ADDR_W-1 -: 5] == chipset_pkg::RAM_BASE_TAG);
    assign cga_sel = ~bus.address_enable_n & enable_cga_i
                   & (bus.address[chipset_pkg::ADDR_W-1 -: VRAM_TAG_W]
                      == chipset_pkg::CGA_BASE_TAG[5 -: VRAM_TAG_W]);
    assign mda_sel = ~bus.address_enable_n & enable_mda_i
                   & (bus.address[chipset_pkg::ADDR_W-1 -: VRAM_TAG_W]
                      == chipset_pkg::MDA_BASE_TAG[5 -: VRAM_TAG_W]);

    // any memory cycle on the bus
    assign access = ~bus.memory_read_n | ~bus.memory_write_n;

    byte_ram #(.AW(RAM_AW)) main_ram (
        .clock    (clock),
        .enable_i (ram_sel & access),
        .write_i  (~bus.memory_write_n),
        .addr_i   (bus.address[RAM_AW-1:0]),
        .wdata_i  (bus.wdata),
        .rdata_o  (ram_rdata)
    );

    byte_ram #(.AW(VRAM_AW)) cga_buffer (
        .clock    (clock),
        .enable_i (cga_sel & access),
        .write_i  (~bus.memory_write_n),
        .addr_i   (bus.address[VRAM_AW-1:0]),
        .wdata_i  (bus.wdata),
        .rdata_o  (cga_rdata)
    );

    byte_ram #(.AW(VRAM_AW)) mda_buffer (
        .clock    (clock),
        .enable_i (mda_sel & access),
        .write_i  (~bus.memory_write_n),
        .addr_i   (bus.address[VRAM_AW-1:0]),
        .wdata_i  (bus.wdata),
        .rdata_o  (mda_rdata)
    );

    // one-hot record of which region answered the read
    always_ff @(posedge clock) begin
        if (reset) begin
            read_sel_q <= 3'b000;
        end else if (~bus.memory_read_n) begin
            read_sel_q <= {mda_sel, cga_sel, ram_sel};
        end else begin
            read_sel_q <= 3'b000;
        end
    end

    always_comb begin
        result_o.hit = |read_sel_q;
        case (read_sel_q)
            3'b001:  result_o.data = ram_rdata;
            3'b010:  result_o.data = cga_rdata;
            3'b100:  result_o.data = mda_rdata;
            default: result_o.data = '0;
        endcase
    end

endmodule

/* verilog/read_data_mux.sv */
/*
 * read data mux
 * puts the i/o or memory read result on the cpu data bus, i/o first
 */
`timescale 1ns/1ps

module read_data_mux (
    input  chipset_pkg::read_result_t  io_result_i,
    input  chipset_pkg::read_result_t  memory_result_i,
    output chipset_pkg::data_t         data_bus_out_o,
    output logic                       data_bus_out_from_chipset_o
);

    always_comb begin
        if (io_result_i.hit) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = io_result_i.data;
        end else if (memory_result_i.hit) begin
            data_bus_out_from_chipset_o = 1'b1;
            data_bus_out_o              = memory_result_i.data;
        end else begin
            // nobody answered, bus stays quiet
            data_bus_out_from_chipset_o = 1'b0;
            data_bus_out_o              = '0;
        end
    end

endmodule
